// ==== exec_cluster.f ====
+incdir+include
source/exec_types_pkg.sv
source/cdb_pkg.sv
source/alu_unit.sv
source/mult_unit.sv
source/complete_stage.sv
source/exec_cluster.sv
verification/exec_cluster_sva.sv
verification/exec_cluster_tb.sv

// ==== Makefile ====
# Verilator build and run for the execution cluster
# override any variable on the command line, e.g. make run BUILD_DIR=obj

VERILATOR  ?= verilator
TOP        ?= exec_cluster_tb
FILELIST   ?= exec_cluster.f
BUILD_DIR  ?= build
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -Wno-fatal
EXTRA_ARGS ?=

SIM_EXE := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv) $(wildcard verification/*.sv) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-f $(FILELIST) $(EXTRA_ARGS)

# exit status of the simulator is the result of the run
run: compile
	./$(SIM_EXE)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/exec_cluster_tb.sv ====
////////////////////////////////////////////////////////////
// testbench for the execution cluster
// random issue with a fixed seed and at most one op per cycle
// only tags predicted ready are issued since nothing pushes back
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cluster_cfg.svh"

module exec_cluster_tb;

    localparam int DW         = `DATA_WIDTH;
    localparam int TW         = `TAG_WIDTH;
    localparam int NREG       = `PHYS_REG_SZ;
    localparam int ALU_LAT    = 2;                  // drive edge to lane 0
    localparam int MULT_LAT   = `MULT_STAGES + 1;   // drive edge to lane 1
    localparam int WAIT_LIMIT = 100;                // cycles per wait loop

    typedef struct packed {
        logic [31:0]         due;    // cycle count when the lane is valid
        cdb_pkg::cdb_entry_t entry;
    } expect_t;

    logic                          clock;
    logic                          reset;
    exec_types_pkg::issue_packet_t issue;
    cdb_pkg::cdb_bus_t             cdb;
    cdb_pkg::ready_mask_t          reg_ready;

    int                   seed;
    int                   overlap_count;
    logic [31:0]          cycle;
    expect_t              alu_q[$];
    expect_t              mult_q[$];
    cdb_pkg::ready_mask_t model_ready;   // predicted reg_ready
    cdb_pkg::ready_mask_t avail;         // ready and not just issued
    logic                 clear_pending;
    logic [TW-1:0]        clear_tag;

    exec_cluster uut (
        .clock     (clock),
        .reset     (reset),
        .issue     (issue),
        .cdb       (cdb),
        .reg_ready (reg_ready)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////

    function automatic logic [DW-1:0] reference_result(input exec_types_pkg::alu_op_e op,
                                                       input logic [DW-1:0] a,
                                                       input logic [DW-1:0] b);
        logic [2*DW-1:0] a_ext;
        logic [2*DW-1:0] b_ext;
        logic [2*DW-1:0] product;
        int unsigned     shift;
        a_ext   = {{DW{a[DW-1]}}, a};   // sign extend both
        b_ext   = {{DW{b[DW-1]}}, b};
        product = a_ext * b_ext;
        shift   = b % DW;               // low 5 bits only
        case (op)
            exec_types_pkg::OP_ADD:  return a + b;
            exec_types_pkg::OP_SUB:  return a - b;
            exec_types_pkg::OP_AND:  return a & b;
            exec_types_pkg::OP_OR:   return a | b;
            exec_types_pkg::OP_XOR:  return a ^ b;
            exec_types_pkg::OP_SLL:  return a << shift;
            exec_types_pkg::OP_SRL:  return a >> shift;
            exec_types_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? DW'(1) : DW'(0);
            exec_types_pkg::OP_MUL:  return product[DW-1:0];
            exec_types_pkg::OP_MULH: return product[2*DW-1:DW];
            default:                 return '0;
        endcase
    endfunction

    function automatic logic is_mult(input exec_types_pkg::alu_op_e op);
        return (op == exec_types_pkg::OP_MUL) || (op == exec_types_pkg::OP_MULH);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_cdb_entry(input string name, input cdb_pkg::cdb_entry_t got,
                                   input cdb_pkg::cdb_entry_t exp);
        logic bad;
        // tag and value only matter on a valid lane
        bad = exp.valid ? (got !== exp) : (got.valid !== 1'b0);
        if (bad) begin
            fail_run($sformatf("Mismatch %s: got %h/%h/%h expected %h/%h/%h",
                               name, got.valid, got.p_reg_idx, got.reg_val,
                               exp.valid, exp.p_reg_idx, exp.reg_val));
        end
    endtask

    task automatic check_ready(input string name, input cdb_pkg::ready_mask_t got,
                               input cdb_pkg::ready_mask_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // scoreboard runs at the falling edge where outputs are stable
    always @(negedge clock) begin : compare
        cdb_pkg::cdb_entry_t exp_alu;
        cdb_pkg::cdb_entry_t exp_mult;
        expect_t             item;
        if (!reset) begin
            exp_alu  = '0;
            exp_mult = '0;
            if (alu_q.size() > 0 && alu_q[0].due == cycle) begin
                item    = alu_q.pop_front();
                exp_alu = item.entry;
            end
            if (mult_q.size() > 0 && mult_q[0].due == cycle) begin
                item     = mult_q.pop_front();
                exp_mult = item.entry;
            end
            check_cdb_entry("cdb[0]", cdb[cdb_pkg::CDB_LANE_ALU], exp_alu);
            check_cdb_entry("cdb[1]", cdb[cdb_pkg::CDB_LANE_MULT], exp_mult);
            if (exp_alu.valid && exp_mult.valid) begin
                overlap_count++;
            end

            // sets land with the lane and last cycle's issue clears after them
            if (exp_alu.valid) begin
                model_ready[exp_alu.p_reg_idx] = 1'b1;
            end
            if (exp_mult.valid) begin
                model_ready[exp_mult.p_reg_idx] = 1'b1;
            end
            if (clear_pending) begin
                model_ready[clear_tag] = 1'b0;
            end
            check_ready("reg_ready", reg_ready, model_ready);

            // packet sampled at the next rising edge
            clear_pending = issue.valid;
            clear_tag     = issue.dest_tag;
            avail         = model_ready;
            if (issue.valid) begin
                avail[issue.dest_tag] = 1'b0;
                item.entry.valid      = 1'b1;
                item.entry.p_reg_idx  = issue.dest_tag;
                item.entry.reg_val    = reference_result(issue.op, issue.op_a, issue.op_b);
                if (is_mult(issue.op)) begin
                    item.due = cycle + MULT_LAT;
                    mult_q.push_back(item);
                end else begin
                    item.due = cycle + ALU_LAT;
                    alu_q.push_back(item);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    function automatic logic [DW-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic exec_types_pkg::alu_op_e rand_op(input int unsigned first,
                                                        input int unsigned count);
        logic [3:0] code;
        code = 4'(first + ($unsigned($random(seed)) % count));
        return exec_types_pkg::alu_op_e'(code);
    endfunction

    // first ready tag at or above a random start
    function automatic logic find_free_tag(output logic [TW-1:0] tag);
        int start;
        int idx;
        start = $unsigned($random(seed)) % NREG;
        for (int i = 0; i < NREG; i++) begin
            idx = (start + i) % NREG;
            if (avail[idx]) begin
                tag = TW'(idx);
                return 1'b1;
            end
        end
        tag = '0;
        return 1'b0;
    endfunction

    task automatic issue_op(input exec_types_pkg::alu_op_e op, input logic [DW-1:0] a,
                            input logic [DW-1:0] b);
        exec_types_pkg::issue_packet_t pkt;
        logic [TW-1:0]                 tag;
        logic                          found;
        int                            waited;
        waited = 0;
        @(posedge clock);
        found = find_free_tag(tag);
        while (!found) begin
            issue <= '0;
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("timeout: no free register tag to issue to");
            end
            @(posedge clock);
            found = find_free_tag(tag);
        end
        pkt.valid    = 1'b1;
        pkt.op       = op;
        pkt.dest_tag = tag;
        pkt.op_a     = a;
        pkt.op_b     = b;
        issue <= pkt;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            issue <= '0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        idle_cycles(1);
        while (alu_q.size() > 0 || mult_q.size() > 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("timeout: expected bus results never arrived");
            end
            idle_cycles(1);
        end
    endtask

    initial begin
        seed          = 32'h7314;
        overlap_count = 0;
        cycle         = '0;
        model_ready   = '1;
        avail         = '1;
        clear_pending = 1'b0;
        clear_tag     = '0;
        reset         = 1'b1;
        issue         = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        // idle outputs right after reset
        @(negedge clock);
        check_cdb_entry("cdb[0] after reset", cdb[cdb_pkg::CDB_LANE_ALU], '0);
        check_cdb_entry("cdb[1] after reset", cdb[cdb_pkg::CDB_LANE_MULT], '0);
        check_ready("reg_ready after reset", reg_ready, '1);

        // each ALU op plus shift and compare corners
        for (int i = 0; i < 8; i++) begin
            issue_op(exec_types_pkg::alu_op_e'(4'(i)), rand_word(), rand_word());
        end
        issue_op(exec_types_pkg::OP_SLL, 32'h8000_0001, 32'h0000_0025);  // shift by 5
        issue_op(exec_types_pkg::OP_SRL, 32'hF000_0000, 32'hFFFF_FFE3);  // shift by 3
        issue_op(exec_types_pkg::OP_SLT, 32'hFFFF_FFFB, 32'h0000_0003);
        issue_op(exec_types_pkg::OP_SLT, 32'h0000_0003, 32'hFFFF_FFFB);
        issue_op(exec_types_pkg::OP_SUB, 32'h0000_0000, 32'h0000_0001);
        wait_drain();

        // single multiplies with one in flight
        for (int i = 0; i < 12; i++) begin
            issue_op(rand_op(8, 2), rand_word(), rand_word());
            idle_cycles(MULT_LAT);
        end
        issue_op(exec_types_pkg::OP_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        issue_op(exec_types_pkg::OP_MULH, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        issue_op(exec_types_pkg::OP_MULH, 32'h8000_0000, 32'h8000_0000);
        issue_op(exec_types_pkg::OP_MULH, 32'h7FFF_FFFF, 32'h8000_0000);
        wait_drain();

        // back-to-back multiplies
        for (int i = 0; i < 16; i++) begin
            issue_op(rand_op(8, 2), rand_word(), rand_word());
        end
        wait_drain();

        // ALU op two cycles behind a multiply so both finish together
        for (int i = 0; i < 6; i++) begin
            issue_op(exec_types_pkg::OP_MUL, rand_word(), rand_word());
            idle_cycles(1);
            issue_op(rand_op(0, 8), rand_word(), rand_word());
        end
        wait_drain();

        // random mix with idle gaps
        for (int i = 0; i < 400; i++) begin
            if (($unsigned($random(seed)) % 4) == 0) begin
                idle_cycles(1);
            end else begin
                issue_op(rand_op(0, 10), rand_word(), rand_word());
            end
        end
        wait_drain();
        idle_cycles(4);  // ready bits must hold

        if (overlap_count == 0) begin
            fail_run("no cycle carried results on both bus lanes");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== verification/exec_cluster_sva.sv ====
////////////////////////////////////////////////////////////
// bus and ready bit properties of the completion stage
// bound into every complete_stage instance
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cluster_cfg.svh"

module exec_cluster_sva (
    input logic                          clock,
    input logic                          reset,
    input exec_types_pkg::issue_packet_t issue,
    input cdb_pkg::cdb_bus_t             cdb,
    input cdb_pkg::ready_mask_t          reg_ready
);

    localparam int MULT_LAT = `MULT_STAGES + 1;  // issue edge to lane 1

    logic mult_issue;

    assign mult_issue = issue.valid &&
                        ((issue.op == exec_types_pkg::OP_MUL) ||
                         (issue.op == exec_types_pkg::OP_MULH));

    // lane strobes are never unknown once out of reset
    lane_valid_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(cdb[cdb_pkg::CDB_LANE_ALU].valid) &&
        !$isunknown(cdb[cdb_pkg::CDB_LANE_MULT].valid))
        else $error("bus lane valid is unknown after reset");

    alu_lane_ready: assert property (@(posedge clock) disable iff (reset)
        cdb[cdb_pkg::CDB_LANE_ALU].valid |->
            reg_ready[cdb[cdb_pkg::CDB_LANE_ALU].p_reg_idx])
        else $error("ALU lane valid without its ready bit set");

    mult_lane_ready: assert property (@(posedge clock) disable iff (reset)
        cdb[cdb_pkg::CDB_LANE_MULT].valid |->
            reg_ready[cdb[cdb_pkg::CDB_LANE_MULT].p_reg_idx])
        else $error("multiplier lane valid without its ready bit set");

    mult_latency: assert property (@(posedge clock) disable iff (reset)
        mult_issue |-> ##MULT_LAT cdb[cdb_pkg::CDB_LANE_MULT].valid)
        else $error("multiply not on lane 1 after the expected latency");

endmodule

bind complete_stage exec_cluster_sva u_sva (
    .clock     (clock),
    .reset     (reset),
    .issue     (issue),
    .cdb       (cdb),
    .reg_ready (reg_ready)
);

// ==== source/exec_cluster.sv ====
////////////////////////////////////////////////////////////
// execution cluster top: ALU, multiplier, completion
// no back-pressure, so never issue to a tag that is not ready
// at most one issue per cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cluster_cfg.svh"

module exec_cluster (
    input  logic                          clock,
    input  logic                          reset,
    input  exec_types_pkg::issue_packet_t issue,
    output cdb_pkg::cdb_bus_t             cdb,
    output cdb_pkg::ready_mask_t          reg_ready
);

    exec_types_pkg::fu_result_t alu_result;
    exec_types_pkg::fu_result_t mult_result;

    // both units see the same packet and filter on op class
    alu_unit u_alu (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .result (alu_result)
    );

    mult_unit u_mult (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .result (mult_result)
    );

    complete_stage u_complete (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),        // for ready clears
        .alu_result  (alu_result),
        .mult_result (mult_result),
        .cdb         (cdb),
        .reg_ready   (reg_ready)
    );

endmodule

// ==== source/complete_stage.sv ====
////////////////////////////////////////////////////////////
// completion: unit results onto fixed bus lanes
// ready bit cleared by issue, set with the bus strobe
// a clear and a set on one tag in one cycle leaves it clear
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cluster_cfg.svh"

module complete_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  exec_types_pkg::issue_packet_t issue,
    input  exec_types_pkg::fu_result_t    alu_result,
    input  exec_types_pkg::fu_result_t    mult_result,
    output cdb_pkg::cdb_bus_t             cdb,
    output cdb_pkg::ready_mask_t          reg_ready
);

    cdb_pkg::ready_mask_t set_mask;
    cdb_pkg::ready_mask_t clear_mask;

    ////////////////////////////////////////////////////////////
    // bus lanes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        cdb[cdb_pkg::CDB_LANE_ALU].p_reg_idx  <= alu_result.dest_tag;
        cdb[cdb_pkg::CDB_LANE_ALU].reg_val    <= alu_result.value;
        cdb[cdb_pkg::CDB_LANE_MULT].p_reg_idx <= mult_result.dest_tag;
        cdb[cdb_pkg::CDB_LANE_MULT].reg_val   <= mult_result.value;
        if (reset) begin
            cdb[cdb_pkg::CDB_LANE_ALU].valid  <= 1'b0;
            cdb[cdb_pkg::CDB_LANE_MULT].valid <= 1'b0;
        end else begin
            cdb[cdb_pkg::CDB_LANE_ALU].valid  <= alu_result.valid;
            cdb[cdb_pkg::CDB_LANE_MULT].valid <= mult_result.valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // ready mask
    ////////////////////////////////////////////////////////////

    // decode the tags
    always_comb begin
        set_mask   = '0;
        clear_mask = '0;
        if (alu_result.valid) begin
            set_mask[alu_result.dest_tag] = 1'b1;
        end
        if (mult_result.valid) begin
            set_mask[mult_result.dest_tag] = 1'b1;
        end
        if (issue.valid) begin
            clear_mask[issue.dest_tag] = 1'b1;  // new producer in flight
        end
    end

    // set lands on the same edge as the bus lane
    always_ff @(posedge clock) begin
        if (reset) begin
            reg_ready <= '1;  // nothing outstanding
        end else begin
            reg_ready <= (reg_ready | set_mask) & ~clear_mask;
        end
    end

endmodule

// ==== source/mult_unit.sv ====
////////////////////////////////////////////////////////////
// pipelined signed multiplier
// accepts one multiply per cycle, results leave in order
// latency is MULT_STAGES, which must be at least 3
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cluster_cfg.svh"

module mult_unit (
    input  logic                         clock,
    input  logic                         reset,
    input  exec_types_pkg::issue_packet_t issue,
    output exec_types_pkg::fu_result_t    result
);

    localparam int DW   = `DATA_WIDTH;
    localparam int HALF = `DATA_WIDTH / 2;
    localparam int MID  = `MULT_STAGES - 2;  // sum and delay stages

    // stage 0: partial products
    logic signed [2*DW-1:0]    pp_lo_next, pp_hi_next;
    logic signed [2*DW-1:0]    pp_lo, pp_hi;
    logic                      pp_valid;
    logic [`TAG_WIDTH-1:0]     pp_tag;
    exec_types_pkg::alu_op_e   pp_op;

    // middle stages: full product
    logic [MID-1:0]            mid_valid;
    logic [`TAG_WIDTH-1:0]     mid_tag  [MID];
    exec_types_pkg::alu_op_e   mid_op   [MID];
    logic signed [2*DW-1:0]    mid_prod [MID];

    // op_b split as signed upper half and unsigned lower half
    assign pp_lo_next = $signed(issue.op_a) * $signed({1'b0, issue.op_b[HALF-1:0]});
    assign pp_hi_next = $signed(issue.op_a) * $signed(issue.op_b[DW-1:HALF]);

    ////////////////////////////////////////////////////////////
    // pipeline
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        pp_tag <= issue.dest_tag;
        pp_op  <= issue.op;
        pp_lo  <= pp_lo_next;
        pp_hi  <= pp_hi_next;

        mid_tag[0]  <= pp_tag;
        mid_op[0]   <= pp_op;
        mid_prod[0] <= (pp_hi <<< HALF) + pp_lo;  // combine partials
        for (int i = 1; i < MID; i++) begin
            mid_tag[i]  <= mid_tag[i-1];
            mid_op[i]   <= mid_op[i-1];
            mid_prod[i] <= mid_prod[i-1];
        end

        // last stage picks the half
        result.dest_tag <= mid_tag[MID-1];
        if (mid_op[MID-1] == exec_types_pkg::OP_MULH) begin
            result.value <= mid_prod[MID-1][2*DW-1:DW];
        end else begin
            result.value <= mid_prod[MID-1][DW-1:0];
        end

        if (reset) begin
            pp_valid     <= 1'b0;
            mid_valid    <= '0;
            result.valid <= 1'b0;
        end else begin
            pp_valid     <= issue.valid && exec_types_pkg::is_mult_op(issue.op);
            mid_valid[0] <= pp_valid;
            for (int i = 1; i < MID; i++) begin
                mid_valid[i] <= mid_valid[i-1];
            end
            result.valid <= mid_valid[MID-1];
        end
    end

endmodule

// ==== source/alu_unit.sv ====
////////////////////////////////////////////////////////////
// single-cycle integer ALU
// takes every valid non-multiply issue, result one cycle later
// no stall input, the bus lane is always free
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cluster_cfg.svh"

module alu_unit (
    input  logic                         clock,
    input  logic                         reset,
    input  exec_types_pkg::issue_packet_t issue,
    output exec_types_pkg::fu_result_t    result
);

    localparam int DW      = `DATA_WIDTH;
    localparam int SHAMT_W = $clog2(`DATA_WIDTH);

    logic [DW-1:0]      alu_value;
    logic [SHAMT_W-1:0] shamt;
    logic               accept;

    assign shamt  = issue.op_b[SHAMT_W-1:0];  // low bits only
    assign accept = issue.valid && !exec_types_pkg::is_mult_op(issue.op);

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (issue.op)
            exec_types_pkg::OP_ADD: alu_value = issue.op_a + issue.op_b;
            exec_types_pkg::OP_SUB: alu_value = issue.op_a - issue.op_b;
            exec_types_pkg::OP_AND: alu_value = issue.op_a & issue.op_b;
            exec_types_pkg::OP_OR:  alu_value = issue.op_a | issue.op_b;
            exec_types_pkg::OP_XOR: alu_value = issue.op_a ^ issue.op_b;
            exec_types_pkg::OP_SLL: alu_value = issue.op_a << shamt;
            exec_types_pkg::OP_SRL: alu_value = issue.op_a >> shamt;
            exec_types_pkg::OP_SLT: begin
                // signed compare, zero extended flag
                alu_value = {{(DW-1){1'b0}},
                             ($signed(issue.op_a) < $signed(issue.op_b))};
            end
            default: alu_value = '0;  // multiplies go elsewhere
        endcase
    end

    ////////////////////////////////////////////////////////////
    // result register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        result.dest_tag <= issue.dest_tag;
        result.value    <= alu_value;
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= accept;  // strobe, one cycle
        end
    end

endmodule

// ==== source/cdb_pkg.sv ====
////////////////////////////////////////////////////////////
// common data bus types
// two lanes, each owned by one unit, no arbitration
////////////////////////////////////////////////////////////

`include "exec_cluster_cfg.svh"

package cdb_pkg;

    typedef struct packed {
        logic                    valid;      // one-cycle strobe
        logic [`TAG_WIDTH-1:0]   p_reg_idx;  // physical tag
        logic [`DATA_WIDTH-1:0]  reg_val;
    } cdb_entry_t;

    typedef cdb_entry_t [1:0] cdb_bus_t;

    // fixed lane owners
    localparam int CDB_LANE_ALU  = 0;
    localparam int CDB_LANE_MULT = 1;

    // one ready bit per physical tag
    typedef logic [`PHYS_REG_SZ-1:0] ready_mask_t;

endpackage

// ==== source/exec_types_pkg.sv ====
////////////////////////////////////////////////////////////
// issue side and functional unit types
// opcodes are 4 bits, multiplies sit above the ALU group
// shifts use the low 5 bits of op_b, SLT is signed
////////////////////////////////////////////////////////////

`include "exec_cluster_cfg.svh"

package exec_types_pkg;

    // operation codes
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SLT  = 4'd7,  // signed, gives 1 or 0
        OP_MUL  = 4'd8,  // low half of signed product
        OP_MULH = 4'd9   // high half of signed product
    } alu_op_e;

    // one issued operation, valid is a single-cycle strobe
    typedef struct packed {
        logic                    valid;
        alu_op_e                 op;
        logic [`TAG_WIDTH-1:0]   dest_tag;
        logic [`DATA_WIDTH-1:0]  op_a;
        logic [`DATA_WIDTH-1:0]  op_b;
    } issue_packet_t;

    // unit output, valid for one cycle
    typedef struct packed {
        logic                    valid;
        logic [`TAG_WIDTH-1:0]   dest_tag;
        logic [`DATA_WIDTH-1:0]  value;
    } fu_result_t;

    // splits issue traffic between the units
    function automatic logic is_mult_op(alu_op_e op);
        return (op == OP_MUL) || (op == OP_MULH);
    endfunction

endpackage

// ==== include/exec_cluster_cfg.svh ====
////////////////////////////////////////////////////////////
// sizing for the execution cluster
// TAG_WIDTH must cover PHYS_REG_SZ tags
// MULT_STAGES must be 3 or more (operand, sum, select stages)
////////////////////////////////////////////////////////////

`ifndef EXEC_CLUSTER_CFG_SVH
`define EXEC_CLUSTER_CFG_SVH

// operand and result width
`define DATA_WIDTH  32

// physical register tags
`define PHYS_REG_SZ 32
`define TAG_WIDTH   5

// multiplier latency, issue to unit result
`define MULT_STAGES 3

`endif
